// File: rtl/br_macros.svh
`ifndef BR_MACROS_SVH
`define BR_MACROS_SVH

// branch reservation station slots
`define BR_RS_DEPTH 4

// reorder buffer tag
`define ROB_ID_W 5

// physical register tag
`define PHY_REG_W 6

// architectural register number
`define ARCH_REG_W 5

`endif

// File: rtl/cpu_types_pkg.sv
`include "br_macros.svh"

package cpu_types_pkg;

    // data and address words
    typedef logic [31:0] word_t;

    // reorder buffer tag
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // renamed destination and source tags
    typedef logic [`PHY_REG_W-1:0] phy_reg_t;

    // architectural register number, x0..x31
    typedef logic [`ARCH_REG_W-1:0] arch_reg_t;

endpackage

// File: rtl/br_uop_pkg.sv
package br_uop_pkg;

    // branch and jump opcodes seen by the branch unit
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } br_op_t;

    // reservation station slot life cycle
    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_READY = 2'd2
    } rs_slot_state_t;

endpackage

// File: rtl/br_itf.sv
// issue path from the branch station into the branch unit
interface br_issue_itf
    import cpu_types_pkg::*;
    import br_uop_pkg::*;
();
    logic      valid;
    br_op_t    op;
    rob_id_t   rob_id;
    arch_reg_t rd_arch;
    phy_reg_t  rd_phy;
    word_t     pc;
    word_t     imm;
    word_t     rs1_value;
    word_t     rs2_value;
    logic      predict_taken;
    word_t     predict_target;

    modport rs (
        output valid, op, rob_id, rd_arch, rd_phy, pc, imm,
        output rs1_value, rs2_value, predict_taken, predict_target
    );

    modport fu (
        input valid, op, rob_id, rd_arch, rd_phy, pc, imm,
        input rs1_value, rs2_value, predict_taken, predict_target
    );
endinterface

// result bus
interface cdb_itf
    import cpu_types_pkg::*;
();
    logic      valid;
    rob_id_t   rob_id;
    arch_reg_t rd_arch;
    phy_reg_t  rd_phy;
    word_t     rd_value;

    modport fu   (output valid, rob_id, rd_arch, rd_phy, rd_value);
    modport sink (input valid, rob_id, rd_arch, rd_phy, rd_value);
endinterface

// branch resolution bus, same timing as the result bus
interface br_cdb_itf
    import cpu_types_pkg::*;
();
    logic    valid;
    rob_id_t rob_id;
    logic    miss_predict;
    word_t   target;

    modport fu   (output valid, rob_id, miss_predict, target);
    modport sink (input valid, rob_id, miss_predict, target);
endinterface

// File: rtl/br_rs.sv
`include "br_macros.svh"

module br_rs
    import cpu_types_pkg::*;
    import br_uop_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      backend_flush,
    input  logic      disp_valid,
    output logic      disp_ready,
    input  br_op_t    disp_op,
    input  rob_id_t   disp_rob_id,
    input  arch_reg_t disp_rd_arch,
    input  phy_reg_t  disp_rd_phy,
    input  word_t     disp_pc,
    input  word_t     disp_imm,
    input  logic      disp_rs1_ready,
    input  logic      disp_rs2_ready,
    input  phy_reg_t  disp_rs1_phy,
    input  phy_reg_t  disp_rs2_phy,
    input  word_t     disp_rs1_value,
    input  word_t     disp_rs2_value,
    input  logic      disp_predict_taken,
    input  word_t     disp_predict_target,
    input  logic      wb_valid,
    input  phy_reg_t  wb_phy,
    input  word_t     wb_value,
    br_issue_itf.rs   issue
);

    localparam int DEPTH = `BR_RS_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // control state
    rs_slot_state_t   state [DEPTH];
    // age is the number of older entries, 0 is the oldest
    logic [IDX_W-1:0] age   [DEPTH];

    // payload
    br_op_t    slot_op        [DEPTH];
    rob_id_t   slot_rob_id    [DEPTH];
    arch_reg_t slot_rd_arch   [DEPTH];
    phy_reg_t  slot_rd_phy    [DEPTH];
    word_t     slot_pc        [DEPTH];
    word_t     slot_imm       [DEPTH];
    logic      slot_rs1_rdy   [DEPTH];
    logic      slot_rs2_rdy   [DEPTH];
    phy_reg_t  slot_rs1_phy   [DEPTH];
    phy_reg_t  slot_rs2_phy   [DEPTH];
    word_t     slot_rs1_value [DEPTH];
    word_t     slot_rs2_value [DEPTH];
    logic      slot_pred_taken  [DEPTH];
    word_t     slot_pred_target [DEPTH];

    logic [DEPTH-1:0] rs1_hit;
    logic [DEPTH-1:0] rs2_hit;
    logic             disp_rs1_hit;
    logic             disp_rs2_hit;
    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             sel_found;
    logic [IDX_W-1:0] sel_idx;
    logic [IDX_W-1:0] sel_age;
    logic [CNT_W-1:0] occ_cnt;
    logic             disp_fire;

    ////////////////////////////////////////////////////////////
    // operand wakeup
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            rs1_hit[i] = (state[i] == SLOT_WAIT) && !slot_rs1_rdy[i] && wb_valid &&
                         (wb_phy == slot_rs1_phy[i]);
            rs2_hit[i] = (state[i] == SLOT_WAIT) && !slot_rs2_rdy[i] && wb_valid &&
                         (wb_phy == slot_rs2_phy[i]);
        end
    end

    // bypass a writeback arriving with the dispatch
    assign disp_rs1_hit = !disp_rs1_ready && wb_valid && (wb_phy == disp_rs1_phy);
    assign disp_rs2_hit = !disp_rs2_ready && wb_valid && (wb_phy == disp_rs2_phy);

    ////////////////////////////////////////////////////////////
    // free slot and oldest ready select
    ////////////////////////////////////////////////////////////

    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        sel_found  = 1'b0;
        sel_idx    = '0;
        sel_age    = '0;
        occ_cnt    = '0;
        // downward scan so the lowest free slot wins
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (state[i] == SLOT_FREE) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end else begin
                occ_cnt = occ_cnt + 1'b1;
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (state[i] == SLOT_READY && (!sel_found || age[i] < sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
                sel_age   = age[i];
            end
        end
    end

    assign disp_ready = free_found;
    assign disp_fire  = disp_valid && free_found && !backend_flush;

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= SLOT_FREE;
                age[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (sel_found && sel_idx == IDX_W'(i)) begin
                    state[i] <= SLOT_FREE;
                end else if (state[i] == SLOT_WAIT && (slot_rs1_rdy[i] || rs1_hit[i]) &&
                             (slot_rs2_rdy[i] || rs2_hit[i])) begin
                    state[i] <= SLOT_READY;
                end
                // entries younger than the issued one move up
                if (sel_found && state[i] != SLOT_FREE && age[i] > sel_age) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (disp_fire) begin
                state[free_idx] <= ((disp_rs1_ready || disp_rs1_hit) &&
                                    (disp_rs2_ready || disp_rs2_hit)) ? SLOT_READY : SLOT_WAIT;
                age[free_idx]   <= IDX_W'(occ_cnt - CNT_W'(sel_found));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (disp_fire && free_idx == IDX_W'(i)) begin
                slot_op[i]          <= disp_op;
                slot_rob_id[i]      <= disp_rob_id;
                slot_rd_arch[i]     <= disp_rd_arch;
                slot_rd_phy[i]      <= disp_rd_phy;
                slot_pc[i]          <= disp_pc;
                slot_imm[i]         <= disp_imm;
                slot_rs1_rdy[i]     <= disp_rs1_ready || disp_rs1_hit;
                slot_rs2_rdy[i]     <= disp_rs2_ready || disp_rs2_hit;
                slot_rs1_phy[i]     <= disp_rs1_phy;
                slot_rs2_phy[i]     <= disp_rs2_phy;
                slot_rs1_value[i]   <= disp_rs1_hit ? wb_value : disp_rs1_value;
                slot_rs2_value[i]   <= disp_rs2_hit ? wb_value : disp_rs2_value;
                slot_pred_taken[i]  <= disp_predict_taken;
                slot_pred_target[i] <= disp_predict_target;
            end else begin
                if (rs1_hit[i]) begin
                    slot_rs1_rdy[i]   <= 1'b1;
                    slot_rs1_value[i] <= wb_value;
                end
                if (rs2_hit[i]) begin
                    slot_rs2_rdy[i]   <= 1'b1;
                    slot_rs2_value[i] <= wb_value;
                end
            end
        end
    end

    // issue straight from the selected slot
    assign issue.valid          = sel_found;
    assign issue.op             = slot_op[sel_idx];
    assign issue.rob_id         = slot_rob_id[sel_idx];
    assign issue.rd_arch        = slot_rd_arch[sel_idx];
    assign issue.rd_phy         = slot_rd_phy[sel_idx];
    assign issue.pc             = slot_pc[sel_idx];
    assign issue.imm            = slot_imm[sel_idx];
    assign issue.rs1_value      = slot_rs1_value[sel_idx];
    assign issue.rs2_value      = slot_rs2_value[sel_idx];
    assign issue.predict_taken  = slot_pred_taken[sel_idx];
    assign issue.predict_target = slot_pred_target[sel_idx];

endmodule

// File: rtl/fu_br.sv
module fu_br
    import cpu_types_pkg::*;
    import br_uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    backend_flush,
    br_issue_itf.fu issue,
    cdb_itf.fu      cdb,
    br_cdb_itf.fu   br_cdb
);

    // stage 1, the issued micro-op
    logic      s1_valid;
    br_op_t    s1_op;
    rob_id_t   s1_rob_id;
    arch_reg_t s1_rd_arch;
    phy_reg_t  s1_rd_phy;
    word_t     s1_pc;
    word_t     s1_imm;
    word_t     s1_rs1;
    word_t     s1_rs2;
    logic      s1_pred_taken;
    word_t     s1_pred_target;

    // stage 2, the resolved result
    logic      s2_valid;
    rob_id_t   s2_rob_id;
    arch_reg_t s2_rd_arch;
    phy_reg_t  s2_rd_phy;
    word_t     s2_link;
    logic      s2_miss;
    word_t     s2_target;

    logic  taken;
    word_t jalr_sum;
    word_t target;
    word_t link;
    logic  miss;

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            s1_op          <= issue.op;
            s1_rob_id      <= issue.rob_id;
            s1_rd_arch     <= issue.rd_arch;
            s1_rd_phy      <= issue.rd_phy;
            s1_pc          <= issue.pc;
            s1_imm         <= issue.imm;
            s1_rs1         <= issue.rs1_value;
            s1_rs2         <= issue.rs2_value;
            s1_pred_taken  <= issue.predict_taken;
            s1_pred_target <= issue.predict_target;
        end
    end

    ////////////////////////////////////////////////////////////
    // resolve
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (s1_op)
            BR_BEQ:  taken = (s1_rs1 == s1_rs2);
            BR_BNE:  taken = (s1_rs1 != s1_rs2);
            BR_BLT:  taken = ($signed(s1_rs1) < $signed(s1_rs2));
            BR_BGE:  taken = ($signed(s1_rs1) >= $signed(s1_rs2));
            BR_BLTU: taken = (s1_rs1 < s1_rs2);
            BR_BGEU: taken = (s1_rs1 >= s1_rs2);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
        endcase
    end

    assign jalr_sum = s1_rs1 + s1_imm;
    assign link     = s1_pc + 32'd4;

    always_comb begin
        if (!taken) begin
            target = link;
        end else if (s1_op == BR_JALR) begin
            // jalr drops the low bit
            target = {jalr_sum[31:1], 1'b0};
        end else begin
            target = s1_pc + s1_imm;
        end
    end

    // wrong direction or wrong target
    assign miss = (taken != s1_pred_taken) || (target != s1_pred_target);

    always_ff @(posedge clk) begin
        if (rst || backend_flush) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_rob_id  <= s1_rob_id;
            s2_rd_arch <= s1_rd_arch;
            s2_rd_phy  <= s1_rd_phy;
            s2_link    <= link;
            s2_miss    <= miss;
            s2_target  <= target;
        end
    end

    assign cdb.valid    = s2_valid;
    assign cdb.rob_id   = s2_rob_id;
    assign cdb.rd_arch  = s2_rd_arch;
    assign cdb.rd_phy   = s2_rd_phy;
    assign cdb.rd_value = s2_link;

    assign br_cdb.valid        = s2_valid;
    assign br_cdb.rob_id       = s2_rob_id;
    assign br_cdb.miss_predict = s2_miss;
    assign br_cdb.target       = s2_target;

endmodule

// File: rtl/br_perf_counters.sv
module br_perf_counters
    import cpu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    br_cdb_itf.sink  br_cdb,
    output word_t    perf_br_cnt,
    output word_t    perf_mispredict_cnt
);

    // flush leaves these alone, only reset clears them
    always_ff @(posedge clk) begin
        if (rst) begin
            perf_br_cnt         <= '0;
            perf_mispredict_cnt <= '0;
        end else if (br_cdb.valid) begin
            perf_br_cnt <= perf_br_cnt + 32'd1;
            if (br_cdb.miss_predict) begin
                perf_mispredict_cnt <= perf_mispredict_cnt + 32'd1;
            end
        end
    end

endmodule

// File: rtl/br_unit_top.sv
module br_unit_top
    import cpu_types_pkg::*;
    import br_uop_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      backend_flush,
    input  logic      disp_valid,
    output logic      disp_ready,
    input  br_op_t    disp_op,
    input  rob_id_t   disp_rob_id,
    input  arch_reg_t disp_rd_arch,
    input  phy_reg_t  disp_rd_phy,
    input  word_t     disp_pc,
    input  word_t     disp_imm,
    input  logic      disp_rs1_ready,
    input  logic      disp_rs2_ready,
    input  phy_reg_t  disp_rs1_phy,
    input  phy_reg_t  disp_rs2_phy,
    input  word_t     disp_rs1_value,
    input  word_t     disp_rs2_value,
    input  logic      disp_predict_taken,
    input  word_t     disp_predict_target,
    input  logic      wb_valid,
    input  phy_reg_t  wb_phy,
    input  word_t     wb_value,
    output logic      cdb_valid,
    output rob_id_t   cdb_rob_id,
    output arch_reg_t cdb_rd_arch,
    output phy_reg_t  cdb_rd_phy,
    output word_t     cdb_rd_value,
    output logic      br_miss_predict,
    output word_t     br_target,
    output word_t     perf_br_cnt,
    output word_t     perf_mispredict_cnt
);

    br_issue_itf issue_bus ();
    cdb_itf      cdb_bus ();
    br_cdb_itf   br_cdb_bus ();

    br_rs i_br_rs (
        .clk, .rst, .backend_flush,
        .disp_valid, .disp_ready, .disp_op, .disp_rob_id, .disp_rd_arch, .disp_rd_phy,
        .disp_pc, .disp_imm, .disp_rs1_ready, .disp_rs2_ready, .disp_rs1_phy, .disp_rs2_phy,
        .disp_rs1_value, .disp_rs2_value, .disp_predict_taken, .disp_predict_target,
        .wb_valid, .wb_phy, .wb_value,
        .issue (issue_bus.rs)
    );

    fu_br i_fu_br (
        .clk, .rst, .backend_flush,
        .issue  (issue_bus.fu),
        .cdb    (cdb_bus.fu),
        .br_cdb (br_cdb_bus.fu)
    );

    br_perf_counters i_br_perf_counters (
        .clk, .rst,
        .br_cdb (br_cdb_bus.sink),
        .perf_br_cnt,
        .perf_mispredict_cnt
    );

    assign cdb_valid    = cdb_bus.valid;
    assign cdb_rob_id   = cdb_bus.rob_id;
    assign cdb_rd_arch  = cdb_bus.rd_arch;
    assign cdb_rd_phy   = cdb_bus.rd_phy;
    assign cdb_rd_value = cdb_bus.rd_value;

    // resolution valid and rob_id match the result bus
    assign br_miss_predict = br_cdb_bus.miss_predict;
    assign br_target       = br_cdb_bus.target;

endmodule

// File: tests/br_unit_assert.sv
module br_unit_assert
    import cpu_types_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  backend_flush,
    input logic  cdb_valid,
    input logic  disp_ready,
    input word_t perf_br_cnt,
    input word_t perf_mispredict_cnt
);

    // number of failed assertions
    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // flush, reset and counter properties
    ////////////////////////////////////////////////////////////

    // both unit stages are cleared by the flush
    no_result_after_flush: assert property (
        @(posedge clk) disable iff (rst) backend_flush |=> !cdb_valid [*2]
    ) else begin
        $error("result bus valid within two cycles of a flush");
        fail_count++;
    end

    // empty station right out of reset
    ready_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> disp_ready
    ) else begin
        $error("disp_ready low after reset");
        fail_count++;
    end

    miss_count_bounded: assert property (
        @(posedge clk) disable iff (rst) perf_mispredict_cnt <= perf_br_cnt
    ) else begin
        $error("misprediction count above branch count");
        fail_count++;
    end

endmodule

bind br_unit_top br_unit_assert i_br_unit_assert (
    .clk                 (clk),
    .rst                 (rst),
    .backend_flush       (backend_flush),
    .cdb_valid           (cdb_valid),
    .disp_ready          (disp_ready),
    .perf_br_cnt         (perf_br_cnt),
    .perf_mispredict_cnt (perf_mispredict_cnt)
);

// File: tests/br_unit_tb.sv
`include "br_macros.svh"

module br_unit_tb
    import cpu_types_pkg::*;
    import br_uop_pkg::*;
();

    localparam int NUM_ROWS = 17;
    localparam int NUM_IDS  = 1 << `ROB_ID_W;

    // one stimulus row
    // blocked operands arrive by writeback after wb_delay cycles
    typedef struct packed {
        br_op_t     op;
        word_t      pc;
        word_t      imm;
        word_t      rs1;
        word_t      rs2;
        logic       rs1_rdy;
        logic       rs2_rdy;
        phy_reg_t   rs1_phy;
        phy_reg_t   rs2_phy;
        logic       pred_taken;
        word_t      pred_target;
        logic [3:0] wb_delay;
    } br_row_t;

    logic clk, rst, backend_flush;
    logic disp_valid, disp_ready;
    br_op_t disp_op;
    rob_id_t disp_rob_id;
    arch_reg_t disp_rd_arch;
    phy_reg_t disp_rd_phy, disp_rs1_phy, disp_rs2_phy, wb_phy;
    word_t disp_pc, disp_imm, disp_rs1_value, disp_rs2_value, disp_predict_target, wb_value;
    logic disp_rs1_ready, disp_rs2_ready, disp_predict_taken, wb_valid;
    logic cdb_valid, br_miss_predict;
    rob_id_t cdb_rob_id;
    arch_reg_t cdb_rd_arch;
    phy_reg_t cdb_rd_phy;
    word_t cdb_rd_value, br_target, perf_br_cnt, perf_mispredict_cnt;

    br_row_t rows [NUM_ROWS];
    string   row_name [NUM_ROWS];

    // reference results indexed by rob_id
    word_t exp_link [NUM_IDS];
    word_t exp_target [NUM_IDS];
    logic  exp_miss [NUM_IDS];
    string exp_name [NUM_IDS];
    logic  pending [NUM_IDS];
    logic  done [NUM_IDS];
    int    wake_left [NUM_IDS];

    int n_tests = 0;
    int n_errors = 0;
    int n_expected = 0;
    int n_miss = 0;
    int seed = 32'h60a6ef0d;

    br_unit_top i_dut (.*);

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model and stimulus tasks
    ////////////////////////////////////////////////////////////

    function automatic void model_branch(input br_row_t r, output word_t link,
                                         output word_t target, output logic miss);
        logic  taken;
        word_t jump_sum;
        link     = r.pc + 32'd4;
        jump_sum = r.rs1 + r.imm;
        case (r.op)
            BR_BEQ:  taken = (r.rs1 == r.rs2);
            BR_BNE:  taken = (r.rs1 != r.rs2);
            BR_BLT:  taken = ($signed(r.rs1) < $signed(r.rs2));
            BR_BGE:  taken = ($signed(r.rs1) >= $signed(r.rs2));
            BR_BLTU: taken = (r.rs1 < r.rs2);
            BR_BGEU: taken = (r.rs1 >= r.rs2);
            default: taken = 1'b1;
        endcase
        if (!taken) begin
            target = link;
        end else if (r.op == BR_JALR) begin
            target = jump_sum & ~32'd1;
        end else begin
            target = r.pc + r.imm;
        end
        miss = (taken != r.pred_taken) || (target != r.pred_target);
    endfunction

    task automatic set_row(input int i, input string name, input br_op_t op, input word_t pc,
                           input word_t imm, input word_t rs1, input word_t rs2,
                           input logic rdy1, input logic rdy2, input logic pt,
                           input word_t ptgt, input int dly);
        rows[i] = '{op, pc, imm, rs1, rs2, rdy1, rdy2, phy_reg_t'(2 * i + 8),
                    phy_reg_t'(2 * i + 9), pt, ptgt, 4'(dly)};
        row_name[i] = name;
    endtask

    task automatic dispatch_row(input int r, input int id, input string name,
                                input bit expect_result);
        word_t link;
        word_t target;
        logic  miss;
        while (!disp_ready) @(negedge clk);
        model_branch(rows[r], link, target, miss);
        if (expect_result) begin
            exp_link[id]   = link;
            exp_target[id] = target;
            exp_miss[id]   = miss;
            exp_name[id]   = name;
            pending[id]    = 1'b1;
            n_expected++;
            if (miss) n_miss++;
        end
        // a delay of 0 wakes rs1 in the dispatch cycle itself
        wake_left[id] = int'(!rows[r].rs1_rdy && rows[r].wb_delay != 0) + int'(!rows[r].rs2_rdy);
        disp_valid          = 1'b1;
        disp_op             = rows[r].op;
        disp_rob_id         = rob_id_t'(id);
        disp_rd_arch        = arch_reg_t'(id);
        disp_rd_phy         = phy_reg_t'(id);
        disp_pc             = rows[r].pc;
        disp_imm            = rows[r].imm;
        disp_rs1_ready      = rows[r].rs1_rdy;
        disp_rs2_ready      = rows[r].rs2_rdy;
        disp_rs1_phy        = rows[r].rs1_phy;
        disp_rs2_phy        = rows[r].rs2_phy;
        disp_rs1_value      = rows[r].rs1_rdy ? rows[r].rs1 : 32'hdead_beef;
        disp_rs2_value      = rows[r].rs2_rdy ? rows[r].rs2 : 32'hdead_beef;
        disp_predict_taken  = rows[r].pred_taken;
        disp_predict_target = rows[r].pred_target;
        if (!rows[r].rs1_rdy && rows[r].wb_delay == 0) begin
            wb_valid = 1'b1;
            wb_phy   = rows[r].rs1_phy;
            wb_value = rows[r].rs1;
        end
        @(negedge clk);
        disp_valid = 1'b0;
        wb_valid   = 1'b0;
    endtask

    task automatic write_back(input phy_reg_t phy, input word_t value, input int id);
        wb_valid  = 1'b1;
        wb_phy    = phy;
        wb_value  = value;
        wake_left[id]--;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic wake_row(input int r, input int id);
        if (rows[r].wb_delay > 1) repeat (rows[r].wb_delay - 1) @(negedge clk);
        if (!rows[r].rs1_rdy && rows[r].wb_delay != 0) write_back(rows[r].rs1_phy, rows[r].rs1, id);
        if (!rows[r].rs2_rdy) write_back(rows[r].rs2_phy, rows[r].rs2, id);
    endtask

    task automatic wait_result(input int id);
        while (!done[id]) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard sampling the result bus mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        int   id;
        logic bad;
        if (!rst && cdb_valid) begin
            id  = int'(cdb_rob_id);
            bad = 1'b0;
            if (!pending[id]) begin
                $display("FAILED rob_id %0d reached the result bus with nothing in flight", id);
                n_errors++;
            end else begin
                pending[id] = 1'b0;
                done[id]    = 1'b1;
                n_tests++;
                if (wake_left[id] != 0) begin
                    $display("FAILED %s gave a result before its operands were written back",
                             exp_name[id]);
                    bad = 1'b1;
                end
                if (cdb_rd_value !== exp_link[id]) begin
                    $display("FAILED %s rd_value expected %h actual %h", exp_name[id],
                             exp_link[id], cdb_rd_value);
                    bad = 1'b1;
                end
                if (br_target !== exp_target[id]) begin
                    $display("FAILED %s target expected %h actual %h", exp_name[id],
                             exp_target[id], br_target);
                    bad = 1'b1;
                end
                if (br_miss_predict !== exp_miss[id]) begin
                    $display("FAILED %s miss_predict expected %b actual %b", exp_name[id],
                             exp_miss[id], br_miss_predict);
                    bad = 1'b1;
                end
                if (cdb_rd_phy !== phy_reg_t'(id)) begin
                    $display("FAILED %s rd_phy expected %h actual %h", exp_name[id],
                             phy_reg_t'(id), cdb_rd_phy);
                    bad = 1'b1;
                end
                if (cdb_rd_arch !== arch_reg_t'(id)) begin
                    $display("FAILED %s rd_arch expected %h actual %h", exp_name[id],
                             arch_reg_t'(id), cdb_rd_arch);
                    bad = 1'b1;
                end
                if (bad) n_errors++;
                else $display("ok     %s", exp_name[id]);
            end
        end
    end

    // worst case row is well under 40 cycles
    initial begin
        repeat (NUM_ROWS * 40 + 200) @(posedge clk);
        $display("timeout: results were missing after %0d cycles", NUM_ROWS * 40 + 200);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int blk[$];
        int err_before;
        int waited;
        clk = 1'b0;
        rst = 1'b1;
        backend_flush = 1'b0;
        disp_valid = 1'b0;
        disp_op = BR_BEQ;
        disp_rob_id = '0;
        disp_rd_arch = '0;
        disp_rd_phy = '0;
        disp_pc = '0;
        disp_imm = '0;
        disp_rs1_ready = 1'b0;
        disp_rs2_ready = 1'b0;
        disp_rs1_phy = '0;
        disp_rs2_phy = '0;
        disp_rs1_value = '0;
        disp_rs2_value = '0;
        disp_predict_taken = 1'b0;
        disp_predict_target = '0;
        wb_valid = 1'b0;
        wb_phy = '0;
        wb_value = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            pending[i] = 1'b0;
            done[i] = 1'b0;
            wake_left[i] = 0;
        end

        // name, op, pc, imm, rs1, rs2, rdy1, rdy2, pred taken, pred target, wb delay
        set_row(0, "beq_equal", BR_BEQ, 'h100, 'h40, 5, 5, 1, 1, 1, 'h140, 0);
        set_row(1, "bne_equal", BR_BNE, 'h200, 'h20, 7, 7, 1, 1, 0, 'h204, 0);
        set_row(2, "blt_min_int", BR_BLT, 'h300, 'hffff_fff0, 'h8000_0000, 1, 1, 1, 0, 'h304, 0);
        set_row(3, "bge_minus_one", BR_BGE, 'h400, 'h8, 'hffff_ffff, 0, 1, 1, 0, 'h404, 0);
        set_row(4, "bltu_wrong_target", BR_BLTU, 'h500, 'h10, 'h8000_0000, 'hffff_ffff,
                1, 1, 1, 'h520, 0);
        set_row(5, "bgeu_equal_max", BR_BGEU, 'h600, 'h30, 'hffff_ffff, 'hffff_ffff,
                1, 1, 1, 'h630, 0);
        set_row(6, "jal", BR_JAL, 'h700, 'h100, 0, 0, 1, 1, 1, 'h800, 0);
        set_row(7, "jalr_odd_sum", BR_JALR, 'h800, 'h3, 'h1000, 0, 1, 1, 1, 'h1002, 0);
        set_row(8, "jalr_wrong_target", BR_JALR, 'h900, 'h5, 'h2000, 0, 1, 1, 1, 'h2005, 0);
        set_row(9, "wake_blt", BR_BLT, 'ha00, 'h20, 3, 4, 0, 1, 1, 'ha20, 3);
        set_row(10, "wake_bgeu_both", BR_BGEU, 'hb00, 'h40, 2, 9, 0, 0, 1, 'hb40, 2);
        set_row(11, "wake_beq_bypass", BR_BEQ, 'hc00, 'h8, 'h55, 'h55, 0, 1, 0, 'hc04, 0);
        set_row(12, "wake_jalr", BR_JALR, 'hd00, 'h11, 'h4000, 0, 0, 1, 1, 'h4010, 5);
        set_row(13, "wake_bne", BR_BNE, 'he00, 'h18, 1, 2, 1, 0, 1, 'he18, 1);
        for (int i = 14; i < NUM_ROWS; i++) begin
            word_t pc;
            word_t imm;
            pc  = word_t'($random(seed)) & 32'h0000_fffc;
            imm = word_t'($random(seed)) & 32'h0000_0ffc;
            set_row(i, $sformatf("random_%0d", i), br_op_t'($unsigned($random(seed)) % 6), pc,
                    imm, $random(seed), $random(seed), 1, 1, $random(seed) & 1, pc + imm, 0);
        end

        repeat (3) @(negedge clk);
        rst = 1'b0;

        // one row at a time
        for (int r = 0; r < NUM_ROWS; r++) begin
            dispatch_row(r, r, row_name[r], 1'b1);
            wake_row(r, r);
            wait_result(r);
        end

        ////////////////////////////////////////////////////////////
        // fill the station with blocked entries
        ////////////////////////////////////////////////////////////
        for (int r = 0; r < NUM_ROWS; r++) begin
            if ((!rows[r].rs1_rdy || !rows[r].rs2_rdy) && rows[r].wb_delay != 0) blk.push_back(r);
        end
        err_before = n_errors;
        n_tests++;
        for (int k = 0; k < `BR_RS_DEPTH; k++) begin
            dispatch_row(blk[k], 20 + k, {"full_", row_name[blk[k]]}, 1'b1);
        end
        if (disp_ready !== 1'b0) begin
            $display("FAILED backpressure disp_ready expected 0 actual %b", disp_ready);
            n_errors++;
        end
        wake_row(blk[0], 20);
        waited = 0;
        while (!disp_ready && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!disp_ready) begin
            $display("FAILED backpressure: disp_ready stayed low after a wakeup");
            n_errors++;
        end
        for (int k = 1; k < `BR_RS_DEPTH; k++) wake_row(blk[k], 20 + k);
        for (int k = 0; k < `BR_RS_DEPTH; k++) wait_result(20 + k);
        if (n_errors == err_before) $display("ok     backpressure");

        // flush catches one entry in the unit and two in the station
        err_before = n_errors;
        n_tests++;
        dispatch_row(9, 26, "flushed", 1'b0);
        dispatch_row(0, 24, "flushed", 1'b0);
        dispatch_row(1, 25, "flushed", 1'b0);
        backend_flush = 1'b1;
        @(negedge clk);
        backend_flush = 1'b0;
        if (disp_ready !== 1'b1) begin
            $display("FAILED flush disp_ready expected 1 actual %b", disp_ready);
            n_errors++;
        end
        write_back(rows[9].rs1_phy, rows[9].rs1, 26);
        repeat (10) @(negedge clk);
        if (n_errors == err_before) $display("ok     flush");

        // counters against the model totals
        err_before = n_errors;
        n_tests++;
        if (perf_br_cnt !== word_t'(n_expected)) begin
            $display("FAILED perf_br_cnt expected %0d actual %0d", n_expected, perf_br_cnt);
            n_errors++;
        end
        if (perf_mispredict_cnt !== word_t'(n_miss)) begin
            $display("FAILED perf_mispredict_cnt expected %0d actual %0d", n_miss,
                     perf_mispredict_cnt);
            n_errors++;
        end
        if (n_errors == err_before) $display("ok     perf_counters");

        if (i_dut.i_br_unit_assert.fail_count != 0) begin
            $display("bound assertions failed %0d times", i_dut.i_br_unit_assert.fail_count);
            n_errors += i_dut.i_br_unit_assert.fail_count;
        end

        $display("%0d tests, %0d errors", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/br_uop_pkg.sv
rtl/br_itf.sv
rtl/br_rs.sv
rtl/fu_br.sv
rtl/br_perf_counters.sv
rtl/br_unit_top.sv
tests/br_unit_assert.sv
tests/br_unit_tb.sv

// File: Bender.yml
package:
  name: br_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_types_pkg.sv
      - rtl/br_uop_pkg.sv
      - rtl/br_itf.sv
      - rtl/br_rs.sv
      - rtl/fu_br.sv
      - rtl/br_perf_counters.sv
      - rtl/br_unit_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/br_unit_assert.sv
      - tests/br_unit_tb.sv
